/* emif_model.f */
+incdir+include
source/emif_sim_pkg.sv
source/emif_bank_storage.sv
source/emif_bank.sv
source/emif_dual_bank.sv
verif/emif_dual_bank_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the dual-bank DDR4 model testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f emif_model.f \
  --top-module emif_dual_bank_tb \
  -o emif_sim

# Keep the simulator output for the result search below
output=$(./obj_dir/emif_sim)
echo "$output"

# The run passes only if the testbench printed its pass line
if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi

/* include/emif_tb_tasks.svh */
// Reference byte merge, bus-driving helpers, burst read and write tasks and directed tests
`ifndef EMIF_TB_TASKS_SVH
`define EMIF_TB_TASKS_SVH

// Enabled bytes take the new word and the others keep the old one
function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
    input logic [DATA_W-1:0] new_w, input logic [BE_W-1:0] be);
  logic [DATA_W-1:0] merged = old_w;
  for (int i = 0; i < BE_W; i++) begin
    if (be[i]) merged[i*8 +: 8] = new_w[i*8 +: 8];
  end
  return merged;
endfunction

// Fills the first n entries of the write buffer with random words
task automatic fill_random(input int n);
  for (int i = 0; i < n; i++) begin
    for (int j = 0; j < DATA_W / 32; j++) begin
      wr_buf[i] = {wr_buf[i][DATA_W-33:0], $random(seed)};
    end
  end
endtask

// Drives one bank's command inputs and points the sampled outputs at that bank
task automatic drive_port(input bit bank, input logic rd, input logic wr,
    input logic [ADDR_W-1:0] addr, input int count, input logic [DATA_W-1:0] data,
    input logic [BE_W-1:0] be);
  sel_b = bank;
  if (bank) {ddr4b_read, ddr4b_write, ddr4b_address, ddr4b_burstcount, ddr4b_writedata,
      ddr4b_byteenable} = {rd, wr, addr, BURST_W'(count), data, be};
  else {ddr4a_read, ddr4a_write, ddr4a_address, ddr4a_burstcount, ddr4a_writedata,
      ddr4a_byteenable} = {rd, wr, addr, BURST_W'(count), data, be};
endtask

task automatic release_port(input bit bank);
  drive_port(bank, 1'b0, 1'b0, '0, 0, '0, '0);
endtask

task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
    input logic [DATA_W-1:0] actual);
  checks++;
  assert (actual === expected) else begin
    errors++;
    $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
  end
endtask

// Counts only the errors raised since the previous test finished
task automatic end_test(input string name);
  tests++;
  if (errors == errors_seen) $display("%s: no errors", name);
  else $display("%s: %0d errors", name, errors - errors_seen);
  errors_seen = errors;
endtask

// Later beats offer the inverted mask, which the bank must ignore
task automatic write_burst(input bit bank, input logic [ADDR_W-1:0] addr, input int n,
    input logic [BE_W-1:0] be, input bit gaps);
  logic [ADDR_W-1:0] a;
  for (int i = 0; i < n; i++) begin
    if (gaps && i > 0) begin
      release_port(bank);
      @(negedge DDR4_USERCLK);
    end
    drive_port(bank, 1'b0, 1'b1, addr, n, wr_buf[i], (i == 0) ? be : ~be);
    @(negedge DDR4_USERCLK);
    check_value("waitrequest", '0, s_wait);
    a = addr + ADDR_W'(i);
    if (bank) ref_b[a] = merge_bytes(ref_b[a], wr_buf[i], be);
    else ref_a[a] = merge_bytes(ref_a[a], wr_buf[i], be);
  end
  release_port(bank);
endtask

// Collects the beats into rd_buf
// lat counts edges from the accepting edge to the first valid beat
task automatic read_burst(input bit bank, input logic [ADDR_W-1:0] addr, input int n,
    output int lat);
  int got = 0;
  int cycles = 0;
  lat = -1;
  drive_port(bank, 1'b1, 1'b0, addr, n, '0, '0);
  @(negedge DDR4_USERCLK);
  release_port(bank);
  check_value("waitrequest", 1, s_wait);
  while (got < n && cycles < n + READ_SLACK) begin
    @(negedge DDR4_USERCLK);
    cycles++;
    if (s_valid) begin
      if (got == 0) lat = cycles;
      rd_buf[got] = s_rdata;
      got++;
      // Waitrequest falls together with the last beat
      check_value("waitrequest", (got < n), s_wait);
    end else if (got > 0) begin
      check_value("readdatavalid", 1, s_valid);
    end
  end
  assert (got == n) else begin
    errors++;
    $display("Read burst of %0d beats returned only %0d beats", n, got);
  end
  @(negedge DDR4_USERCLK);
  check_value("readdatavalid", 0, s_valid);
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic test_reset();
  int lat;
  check_value("ddr4a_readdata", '0, ddr4a_readdata);
  check_value("ddr4b_readdata", '0, ddr4b_readdata);
  check_value("ddr4a_waitrequest,readdatavalid", '0, {ddr4a_waitrequest, ddr4a_readdatavalid});
  check_value("ddr4b_waitrequest,readdatavalid", '0, {ddr4b_waitrequest, ddr4b_readdatavalid});
  read_burst(1'b0, 8'h5a, 1, lat);
  check_value("ddr4a_readdata", '0, rd_buf[0]);
  read_burst(1'b1, 8'hc3, 1, lat);
  check_value("ddr4b_readdata", '0, rd_buf[0]);
  end_test("reset state");
endtask

task automatic test_single();
  int lat;
  fill_random(1);
  write_burst(1'b0, 8'h10, 1, '1, 1'b0);
  read_burst(1'b0, 8'h10, 1, lat);
  check_value("ddr4a_readdatavalid latency", 1, lat);
  check_value("ddr4a_readdata", wr_buf[0], rd_buf[0]);
  end_test("single beat");
endtask

task automatic test_read_burst();
  int lat;
  fill_random(8);
  write_burst(1'b1, 8'h20, 8, '1, 1'b0);
  read_burst(1'b1, 8'h20, 8, lat);
  check_value("ddr4b_readdatavalid latency", 1, lat);
  for (int i = 0; i < 8; i++) begin
    check_value("ddr4b_readdata", ref_b[8'h20 + i], rd_buf[i]);
  end
  end_test("read burst");
endtask

// Mask of the first beat decides every beat of the gapped burst
task automatic test_partial();
  int lat;
  logic [BE_W-1:0] be;
  fill_random(4);
  write_burst(1'b0, 8'h40, 4, '1, 1'b0);
  fill_random(4);
  be = {$random(seed), $random(seed)};
  write_burst(1'b0, 8'h40, 4, be, 1'b1);
  read_burst(1'b0, 8'h40, 4, lat);
  for (int i = 0; i < 4; i++) begin
    check_value("ddr4a_readdata", ref_a[8'h40 + i], rd_buf[i]);
  end
  end_test("partial write burst");
endtask

task automatic test_banks();
  int lat;
  fill_random(1);
  write_burst(1'b0, 8'h77, 1, '1, 1'b0);
  fill_random(1);
  write_burst(1'b1, 8'h77, 1, '1, 1'b0);
  read_burst(1'b0, 8'h77, 1, lat);
  check_value("ddr4a_readdata", ref_a[8'h77], rd_buf[0]);
  read_burst(1'b1, 8'h77, 1, lat);
  check_value("ddr4b_readdata", ref_b[8'h77], rd_buf[0]);
  end_test("bank independence");
endtask

`endif

/* verif/emif_dual_bank_tb.sv */
// Testbench top with clock, reset, watchdog, DUT instance, test sequence and summary
`timescale 1ns/10ps

module emif_dual_bank_tb
  import emif_sim_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 2;
  // Extra cycles a read may take before its missing beats are reported
  localparam int READ_SLACK = 8;
  // Cycle budget of reset, single beat, read burst, partial write and bank tests
  localparam int TEST_CYCLES = 8 + 6 + 20 + 20 + 10;
  localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 200) * CLK_PERIOD;

  logic               DDR4_USERCLK;
  logic               rst_n;

  // Bank a and bank b ports of the DUT
  logic               ddr4a_read;
  logic               ddr4a_write;
  logic               ddr4a_waitrequest;
  logic               ddr4a_readdatavalid;
  logic [ADDR_W-1:0]  ddr4a_address;
  logic [BURST_W-1:0] ddr4a_burstcount;
  logic [DATA_W-1:0]  ddr4a_writedata;
  logic [DATA_W-1:0]  ddr4a_readdata;
  logic [BE_W-1:0]    ddr4a_byteenable;
  logic               ddr4b_read;
  logic               ddr4b_write;
  logic               ddr4b_waitrequest;
  logic               ddr4b_readdatavalid;
  logic [ADDR_W-1:0]  ddr4b_address;
  logic [BURST_W-1:0] ddr4b_burstcount;
  logic [DATA_W-1:0]  ddr4b_writedata;
  logic [DATA_W-1:0]  ddr4b_readdata;
  logic [BE_W-1:0]    ddr4b_byteenable;

  // Outputs of the bank that the last command went to
  logic               sel_b;
  logic               s_wait;
  logic               s_valid;
  logic [DATA_W-1:0]  s_rdata;

  // Burst buffers and the reference copy of each bank
  logic [DATA_W-1:0]  wr_buf [MAX_BURST];
  logic [DATA_W-1:0]  rd_buf [MAX_BURST];
  logic [DATA_W-1:0]  ref_a [DEPTH];
  logic [DATA_W-1:0]  ref_b [DEPTH];

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     errors_seen;

  assign s_wait  = sel_b ? ddr4b_waitrequest : ddr4a_waitrequest;
  assign s_valid = sel_b ? ddr4b_readdatavalid : ddr4a_readdatavalid;
  assign s_rdata = sel_b ? ddr4b_readdata : ddr4a_readdata;

  emif_dual_bank emif_dual_bank_i (.*);

  `include "emif_tb_tasks.svh"

  initial begin
    DDR4_USERCLK = 1'b0;
    forever #(CLK_PERIOD / 2) DDR4_USERCLK = ~DDR4_USERCLK;
  end

  // Ends a run whose test sequence has stalled
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns because the tests did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial begin
    seed = 32'h7a30;
    errors = 0;
    checks = 0;
    tests = 0;
    errors_seen = 0;
    rst_n = 1'b0;
    release_port(1'b0);
    release_port(1'b1);
    // Both banks start out holding zero everywhere
    for (int w = 0; w < DEPTH; w++) begin
      ref_a[w] = '0;
      ref_b[w] = '0;
    end
    repeat (RESET_CYCLES) @(posedge DDR4_USERCLK);
    @(negedge DDR4_USERCLK);
    rst_n = 1'b1;
    test_reset();
    test_single();
    test_read_burst();
    test_partial();
    test_banks();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* source/emif_dual_bank.sv */
// Top of the two-bank DDR4 simulation model, bank a and bank b on one clock and reset
`timescale 1ns/10ps

module emif_dual_bank
  import emif_sim_pkg::*;
(
  input  logic               DDR4_USERCLK,
  input  logic               rst_n,

  // Bank a Avalon-MM port
  input  logic               ddr4a_read,
  input  logic               ddr4a_write,
  input  logic [ADDR_W-1:0]  ddr4a_address,
  input  logic [BURST_W-1:0] ddr4a_burstcount,
  input  logic [DATA_W-1:0]  ddr4a_writedata,
  input  logic [BE_W-1:0]    ddr4a_byteenable,
  output logic               ddr4a_waitrequest,
  output logic [DATA_W-1:0]  ddr4a_readdata,
  output logic               ddr4a_readdatavalid,

  // Bank b Avalon-MM port
  input  logic               ddr4b_read,
  input  logic               ddr4b_write,
  input  logic [ADDR_W-1:0]  ddr4b_address,
  input  logic [BURST_W-1:0] ddr4b_burstcount,
  input  logic [DATA_W-1:0]  ddr4b_writedata,
  input  logic [BE_W-1:0]    ddr4b_byteenable,
  output logic               ddr4b_waitrequest,
  output logic [DATA_W-1:0]  ddr4b_readdata,
  output logic               ddr4b_readdatavalid
);

  // ======================================================================
  // Bank a
  // ======================================================================

  emif_bank bank_a (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .rst_n         (rst_n),
    .read          (ddr4a_read),
    .write         (ddr4a_write),
    .address       (ddr4a_address),
    .burstcount    (ddr4a_burstcount),
    .writedata     (ddr4a_writedata),
    .byteenable    (ddr4a_byteenable),
    .waitrequest   (ddr4a_waitrequest),
    .readdata      (ddr4a_readdata),
    .readdatavalid (ddr4a_readdatavalid)
  );

  // ======================================================================
  // Bank b
  // ======================================================================

  // Fully independent of bank a apart from the shared clock and reset
  emif_bank bank_b (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .rst_n         (rst_n),
    .read          (ddr4b_read),
    .write         (ddr4b_write),
    .address       (ddr4b_address),
    .burstcount    (ddr4b_burstcount),
    .writedata     (ddr4b_writedata),
    .byteenable    (ddr4b_byteenable),
    .waitrequest   (ddr4b_waitrequest),
    .readdata      (ddr4b_readdata),
    .readdatavalid (ddr4b_readdatavalid)
  );

endmodule

/* source/emif_bank.sv */
// Burst controller of one DDR4 bank, sequencing read and write bursts into its storage
`timescale 1ns/10ps

module emif_bank
  import emif_sim_pkg::*;
(
  input  logic               DDR4_USERCLK,
  input  logic               rst_n,
  input  logic               read,
  input  logic               write,
  input  logic [ADDR_W-1:0]  address,
  input  logic [BURST_W-1:0] burstcount,
  input  logic [DATA_W-1:0]  writedata,
  input  logic [BE_W-1:0]    byteenable,
  output logic               waitrequest,
  output logic [DATA_W-1:0]  readdata,
  output logic               readdatavalid
);

  // Controller state and burst bookkeeping
  t_burst_state       state_q;
  logic [BURST_W-1:0] beats_left;
  logic [ADDR_W-1:0]  burst_addr;

  // Mask taken from the first beat, reused for the rest of a write burst
  logic [BE_W-1:0]    burst_be;

  // Command and beat decode
  logic read_cmd;
  logic write_cmd;
  logic write_beat;
  logic last_beat;

  // Storage side
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [BE_W-1:0]   wr_byteenable;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  // ======================================================================
  // Command decode
  // ======================================================================

  // Commands are only looked at in idle, and read wins over write
  assign read_cmd   = (state_q == BURST_IDLE) && read;
  assign write_cmd  = (state_q == BURST_IDLE) && write && !read;

  // Later beats of a write burst arrive whenever the source raises write
  assign write_beat = (state_q == BURST_WRITE) && write;

  assign last_beat  = (beats_left == BURST_W'(1));

  // The master is held off only while read data is being streamed out
  assign waitrequest = (state_q == BURST_READ);

  // ======================================================================
  // Storage controls
  // ======================================================================

  // The first write beat goes straight to the command address
  // Later beats use the tracked address and the captured mask
  always_comb begin
    wr_en         = write_cmd || write_beat;
    wr_addr       = write_cmd ? address : burst_addr;
    wr_byteenable = write_cmd ? byteenable : burst_be;
  end

  assign wr_data = writedata;

  // Read data always comes from the next burst address
  assign rd_addr = burst_addr;

  emif_bank_storage storage_i (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_byteenable (wr_byteenable),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  // ======================================================================
  // Burst FSM
  // ======================================================================

  always_ff @(posedge DDR4_USERCLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= BURST_IDLE;
      beats_left    <= '0;
      burst_addr    <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end else begin
      // Valid is a one-cycle pulse per returned beat
      readdatavalid <= 1'b0;
      case (state_q)
        BURST_IDLE: begin
          if (read_cmd) begin
            state_q    <= BURST_READ;
            beats_left <= burstcount;
            burst_addr <= address;
          end else if (write_cmd) begin
            // First beat is already written at this edge
            beats_left <= burstcount - BURST_W'(1);
            burst_addr <= address + ADDR_W'(1);
            if (burstcount > BURST_W'(1)) begin
              state_q <= BURST_WRITE;
            end
          end
        end
        BURST_READ: begin
          // One word per cycle from consecutive addresses
          readdata      <= rd_data;
          readdatavalid <= 1'b1;
          burst_addr    <= burst_addr + ADDR_W'(1);
          beats_left    <= beats_left - BURST_W'(1);
          if (last_beat) begin
            state_q <= BURST_IDLE;
          end
        end
        BURST_WRITE: begin
          // Idle cycles from the source are simply waited out
          if (write_beat) begin
            burst_addr <= burst_addr + ADDR_W'(1);
            beats_left <= beats_left - BURST_W'(1);
            if (last_beat) begin
              state_q <= BURST_IDLE;
            end
          end
        end
        default: begin
          state_q <= BURST_IDLE;
        end
      endcase
    end
  end

  // The write mask is payload, captured with the first beat
  always_ff @(posedge DDR4_USERCLK) begin
    if (write_cmd) begin
      burst_be <= byteenable;
    end
  end

  // ======================================================================
  // Protocol checks
  // ======================================================================

  // An accepted burst must be between one beat and the limit
  a_burst_len: assert property (@(posedge DDR4_USERCLK) disable iff (!rst_n)
    (read_cmd || write_cmd) |-> (burstcount >= BURST_W'(1)) && (burstcount <= MAX_BURST))
    else $error("emif_bank: illegal burstcount %0d", burstcount);

  // A master must never ask for a read and a write at once
  a_rd_wr_excl: assert property (@(posedge DDR4_USERCLK) disable iff (!rst_n)
    (state_q == BURST_IDLE) |-> !(read && write))
    else $error("emif_bank: read and write both high");

  // A command presented during a read burst would be silently dropped
  a_cmd_in_wait: assert property (@(posedge DDR4_USERCLK) disable iff (!rst_n)
    waitrequest |-> !(read || write))
    else $error("emif_bank: command presented while waitrequest high");

endmodule

/* source/emif_bank_storage.sv */
// Word array of one bank with byte-enable mask expansion and read-modify-write merge
`timescale 1ns/10ps

module emif_bank_storage
  import emif_sim_pkg::*;
(
  input  logic              DDR4_USERCLK,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [BE_W-1:0]   wr_byteenable,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data
);

  // The storage itself, one 512-bit word per address
  logic [DATA_W-1:0] mem [DEPTH];

  // Byte enables widened to one bit per data bit
  logic [DATA_W-1:0] wr_mask;

  // ======================================================================
  // Initial contents
  // ======================================================================

  // Every word starts at zero
  // A word that was never written therefore reads back as zero
  initial begin
    for (int w = 0; w < DEPTH; w++) begin
      mem[w] = '0;
    end
  end

  // ======================================================================
  // Mask expansion
  // ======================================================================

  // Each enable bit covers eight data bits
  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      wr_mask[b*8 +: 8] = {8{wr_byteenable[b]}};
    end
  end

  // ======================================================================
  // Write port
  // ======================================================================

  // Disabled bytes keep their old value
  // Enabled bytes take the new data
  always_ff @(posedge DDR4_USERCLK) begin
    if (wr_en) begin
      mem[wr_addr] <= (mem[wr_addr] & ~wr_mask) | (wr_data & wr_mask);
    end
  end

  // ======================================================================
  // Read port
  // ======================================================================

  // Asynchronous read
  // The controller registers this value into readdata
  assign rd_data = mem[rd_addr];

endmodule

/* source/emif_sim_pkg.sv */
// Shared widths, memory depth, burst limits and the burst state encoding for the DDR4 model

package emif_sim_pkg;

  // ======================================================================
  // Data path widths
  // ======================================================================

  // One memory word, as seen on the 512-bit Avalon-MM data bus
  localparam int DATA_W = 512;

  // One byte enable per byte of the word
  localparam int BE_W = DATA_W / 8;

  // Word address width, which gives 256 words per bank
  localparam int ADDR_W = 8;

  // Number of words held by each bank
  localparam int DEPTH = 1 << ADDR_W;

  // ======================================================================
  // Burst limits
  // ======================================================================

  // Width of the burstcount field on the EMIF Avalon-MM port
  localparam int BURST_W = 7;

  // Largest burst the controller accepts
  localparam int MAX_BURST = 64;

  // ======================================================================
  // Burst controller states
  // ======================================================================

  // A bank is either waiting for a command or working through a burst
  typedef enum logic [1:0] {
    BURST_IDLE  = 2'd0,
    BURST_READ  = 2'd1,
    BURST_WRITE = 2'd2
  } t_burst_state;

endpackage
